// File: flush_pkg.sv
package flush_pkg;

  // ------------------------------------------------------------------------
  // Widths and timing constants
  // ------------------------------------------------------------------------

  // Virtual address width of PCs
  localparam int unsigned VLEN = 32;
  // Pad and self-invalidation counters
  localparam int unsigned CNT_W = 32;
  // Drain counter, saturates after 16 idle cycles
  localparam int unsigned DRAIN_W = 4;
  // Microreset pulse length
  localparam int unsigned RST_UARCH_CYCLES = 16;
  localparam int unsigned RST_CNT_W = $clog2(RST_UARCH_CYCLES);
  // Cycles of cache init hold-off after the microreset
  localparam int unsigned CACHE_INIT_HOLD = 3;
  // Resume step past the fence.t instruction
  localparam int unsigned INSTR_BYTES = 4;

  // ------------------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------------------

  // RISC-V privilege levels
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_lvl_e;

  // fence.t sequence states
  typedef enum logic [2:0] {
    IDLE,
    FLUSH_DCACHE,
    DRAIN_REQS,
    PAD,
    RST_UARCH
  } fence_t_state_e;

  // Config register map
  localparam int unsigned CFG_AW = 2;
  localparam logic [CFG_AW-1:0] CFG_ADDR_PAD = 2'd0;
  localparam logic [CFG_AW-1:0] CFG_ADDR_SELFINVAL = 2'd1;
  localparam logic [CFG_AW-1:0] CFG_ADDR_SRC_SEL = 2'd2;
  localparam logic [CFG_AW-1:0] CFG_ADDR_CEIL = 2'd3;

endpackage

// File: flush_counter.sv
`timescale 1ns/10ps

module flush_counter
  import flush_pkg::*;
#(
  parameter int unsigned WIDTH = CNT_W
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Synchronous clear, highest priority
  input  logic             clear_i,
  // Count enable
  input  logic             en_i,
  // Load d_i, wins over counting
  input  logic             load_i,
  // Count direction, high counts down
  input  logic             down_i,
  input  logic [WIDTH-1:0] d_i,
  output logic [WIDTH-1:0] q_o
);

  logic [WIDTH-1:0] cnt_q;

  assign q_o = cnt_q;

  // Wraps silently in both directions
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clear_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= d_i;
    end else if (en_i) begin
      if (down_i) begin
        cnt_q <= cnt_q - WIDTH'(1);
      end else begin
        cnt_q <= cnt_q + WIDTH'(1);
      end
    end
  end

endmodule

// File: fence_cfg_regs.sv
`timescale 1ns/10ps

module fence_cfg_regs
  import flush_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  // Register port
  input  logic              cfg_we_i,
  input  logic [CFG_AW-1:0] cfg_addr_i,
  input  logic [31:0]       cfg_wdata_i,
  output logic [31:0]       cfg_rdata_o,
  // Settings towards the fence logic
  output logic [CNT_W-1:0]  fence_t_pad_o,
  output logic [CNT_W-1:0]  selfinval_period_o,
  output logic              fence_t_src_sel_o,
  // Ceiling sample from the fence.t sequence
  input  logic              ceil_valid_i,
  input  logic [CNT_W-1:0]  ceil_value_i
);

  logic [CNT_W-1:0] pad_q;
  logic [CNT_W-1:0] selfinval_q;
  logic             src_sel_q;
  logic [CNT_W-1:0] ceil_q;

  assign fence_t_pad_o      = pad_q;
  assign selfinval_period_o = selfinval_q;
  assign fence_t_src_sel_o  = src_sel_q;

  // ------------------------------------------------------------------------
  // Register writes
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pad_q       <= '0;
      selfinval_q <= '0;
      src_sel_q   <= 1'b0;
      ceil_q      <= '0;
    end else begin
      if (cfg_we_i && (cfg_addr_i == CFG_ADDR_PAD)) pad_q <= cfg_wdata_i;
      if (cfg_we_i && (cfg_addr_i == CFG_ADDR_SELFINVAL)) selfinval_q <= cfg_wdata_i;
      if (cfg_we_i && (cfg_addr_i == CFG_ADDR_SRC_SEL)) src_sel_q <= cfg_wdata_i[0];
      // Software write clears the ceiling, any data value
      if (cfg_we_i && (cfg_addr_i == CFG_ADDR_CEIL)) begin
        ceil_q <= '0;
      end else if (ceil_valid_i && (ceil_value_i > ceil_q)) begin
        // Track the worst case seen so far
        ceil_q <= ceil_value_i;
      end
    end
  end

  // Combinational read mux
  always_comb begin
    unique case (cfg_addr_i)
      CFG_ADDR_PAD:       cfg_rdata_o = pad_q;
      CFG_ADDR_SELFINVAL: cfg_rdata_o = selfinval_q;
      CFG_ADDR_SRC_SEL:   cfg_rdata_o = {31'b0, src_sel_q};
      default:            cfg_rdata_o = ceil_q;
    endcase
  end

endmodule

// File: flush_ctrl.sv
`timescale 1ns/10ps

module flush_ctrl
  import flush_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [VLEN-1:0]  boot_addr_i,
  input  logic [VLEN-1:0]  pc_commit_i,
  // Pipeline flush events, single-cycle pulses
  input  logic             mispredict_i,
  input  logic             fence_i,
  input  logic             fence_i_i,
  input  logic             sfence_vma_i,
  input  logic             fence_t_i,
  input  logic             flush_csr_i,
  input  logic             flush_commit_i,
  input  logic             ex_valid_i,
  input  logic             eret_i,
  // Dcache flush handshake
  input  logic             flush_dcache_ack_i,
  input  logic             halt_csr_i,
  input  logic             fence_t_busy_i,
  input  logic [CNT_W-1:0] selfinval_period_i,
  // Flush vector
  output logic             set_pc_commit_o,
  output logic             flush_if_o,
  output logic             flush_unissued_o,
  output logic             flush_id_o,
  output logic             flush_ex_o,
  output logic             flush_bp_o,
  output logic             flush_icache_o,
  output logic             flush_tlb_o,
  output logic             flush_dcache_o,
  output logic             halt_o,
  output logic [VLEN-1:0]  rst_addr_o
);

  logic             pipe_flush;
  logic             trap;
  logic             fence_active_d, fence_active_q;
  logic             flush_dcache;
  logic             selfinval;
  logic [CNT_W-1:0] selfinval_cnt;
  logic [VLEN-1:0]  rst_addr_q;

  // ------------------------------------------------------------------------
  // Flush decode
  // ------------------------------------------------------------------------

  // Events that refetch from the committed PC
  assign pipe_flush = fence_i | fence_i_i | sfence_vma_i | flush_csr_i | flush_commit_i;
  // Exception and eret take the trap PC, not the commit PC
  assign trap       = ex_valid_i | eret_i;

  assign set_pc_commit_o  = pipe_flush & ~trap;
  // Mispredict only clears the front end
  assign flush_if_o       = mispredict_i | pipe_flush | trap;
  assign flush_unissued_o = mispredict_i | pipe_flush | trap;
  assign flush_id_o       = pipe_flush | trap;
  assign flush_ex_o       = pipe_flush | trap;
  assign flush_bp_o       = trap;
  assign flush_icache_o   = fence_i_i | fence_t_i;
  assign flush_tlb_o      = sfence_vma_i;

  // ------------------------------------------------------------------------
  // Write-back dcache flush tracking
  // ------------------------------------------------------------------------
  always_comb begin
    fence_active_d = fence_active_q;
    flush_dcache   = 1'b0;
    // Hold the request until the cache acknowledges
    if (fence_active_q) begin
      if (flush_dcache_ack_i) begin
        fence_active_d = 1'b0;
      end else begin
        flush_dcache = 1'b1;
      end
    end
    if (fence_i || fence_i_i || fence_t_i) begin
      flush_dcache   = 1'b1;
      fence_active_d = 1'b1;
    end
    // Periodic self-invalidation, only when no flush is running
    if (selfinval && !fence_active_q) begin
      flush_dcache   = 1'b1;
      fence_active_d = 1'b1;
    end
  end

  // Self-invalidation countdown, reloaded on every dcache flush
  assign selfinval = (selfinval_cnt == '0) && (selfinval_period_i != '0);

  flush_counter #(
    .WIDTH(CNT_W)
  ) u_selfinval_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clear_i(1'b0),
    .en_i   (|selfinval_period_i),
    .load_i (flush_dcache),
    .down_i (1'b1),
    .d_i    (selfinval_period_i),
    .q_o    (selfinval_cnt)
  );

  // Core stalls during a flush or the fence.t sequence
  assign halt_o     = halt_csr_i | fence_active_q | fence_t_busy_i;
  assign rst_addr_o = rst_addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fence_active_q <= 1'b0;
      flush_dcache_o <= 1'b0;
      rst_addr_q     <= boot_addr_i;
    end else begin
      fence_active_q <= fence_active_d;
      // Registered request towards the cache
      flush_dcache_o <= flush_dcache;
      // Resume after fence.t at the next instruction
      if (fence_t_i) rst_addr_q <= pc_commit_i + VLEN'(INSTR_BYTES);
    end
  end

endmodule

// File: fence_t_fsm.sv
`timescale 1ns/10ps

module fence_t_fsm
  import flush_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             fence_t_i,
  input  logic             flush_dcache_ack_i,
  input  logic             cache_busy_i,
  // Pad timing sources
  input  logic             time_irq_i,
  input  priv_lvl_e        priv_lvl_i,
  input  logic [CNT_W-1:0] fence_t_pad_i,
  input  logic             fence_t_src_sel_i,
  output logic             fence_t_busy_o,
  output logic             stall_cache_o,
  output logic             rst_uarch_no,
  output logic             cache_init_no,
  // Ceiling sample at drain exit
  output logic             ceil_valid_o,
  output logic [CNT_W-1:0] ceil_value_o
);

  fence_t_state_e state_d, state_q;

  logic [DRAIN_W-1:0]         drain_cnt;
  logic                       drain_done;
  logic [CNT_W-1:0]           pad_cnt;
  logic                       load_pad;
  logic [RST_CNT_W-1:0]       rst_cnt;
  logic                       time_irq_q;
  priv_lvl_e                  priv_lvl_q;
  logic [CACHE_INIT_HOLD-1:0] init_hold_q;
  logic                       in_rst;

  // ------------------------------------------------------------------------
  // Sequencer
  // ------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:         if (fence_t_i) state_d = FLUSH_DCACHE;
      // Dcache writes back its dirty lines first
      FLUSH_DCACHE: if (flush_dcache_ack_i) state_d = DRAIN_REQS;
      // Let outstanding cache traffic finish
      DRAIN_REQS:   if (drain_done) state_d = PAD;
      PAD:          if (pad_cnt == '0) state_d = RST_UARCH;
      RST_UARCH:    if (rst_cnt == RST_CNT_W'(RST_UARCH_CYCLES - 1)) state_d = IDLE;
      default:      state_d = IDLE;
    endcase
  end

  assign in_rst         = (state_q == RST_UARCH);
  assign fence_t_busy_o = (state_q != IDLE);
  // Cache takes no new requests during the whole sequence
  assign stall_cache_o  = (state_q != IDLE);
  assign rst_uarch_no   = ~in_rst;
  // Hold off cache init through the pulse and a few cycles past it
  assign cache_init_no  = in_rst | (|init_hold_q);

  // Drain exit needs 16 consecutive idle cycles in the state
  assign drain_done   = (state_q == DRAIN_REQS) && (drain_cnt == '1) && !cache_busy_i;
  assign ceil_valid_o = drain_done;
  assign ceil_value_o = (pad_cnt == '0) ? '0 : fence_t_pad_i - pad_cnt;

  // Timer edge or exit from U mode starts the pad window
  assign load_pad = fence_t_src_sel_i ? ((priv_lvl_q == PRIV_U) && (priv_lvl_i != PRIV_U))
                                      : (time_irq_i & ~time_irq_q);

  flush_counter #(
    .WIDTH(DRAIN_W)
  ) u_drain_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clear_i(cache_busy_i || (state_q != DRAIN_REQS)),
    .en_i   (drain_cnt != '1),
    .load_i (1'b0),
    .down_i (1'b0),
    .d_i    ('0),
    .q_o    (drain_cnt)
  );

  flush_counter #(
    .WIDTH(CNT_W)
  ) u_pad_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clear_i(1'b0),
    .en_i   (|pad_cnt),
    .load_i (load_pad),
    .down_i (1'b1),
    .d_i    (fence_t_pad_i),
    .q_o    (pad_cnt)
  );

  // Microreset pulse length
  flush_counter #(
    .WIDTH(RST_CNT_W)
  ) u_rst_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clear_i(~in_rst),
    .en_i   (1'b1),
    .load_i (1'b0),
    .down_i (1'b0),
    .d_i    ('0),
    .q_o    (rst_cnt)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      time_irq_q  <= 1'b0;
      priv_lvl_q  <= PRIV_M;
      init_hold_q <= '0;
    end else begin
      state_q     <= state_d;
      time_irq_q  <= time_irq_i;
      priv_lvl_q  <= priv_lvl_i;
      // Shift register stretches the hold-off
      init_hold_q <= {init_hold_q[CACHE_INIT_HOLD-2:0], in_rst};
    end
  end

endmodule

// File: flush_unit_top.sv
`timescale 1ns/10ps

module flush_unit_top
  import flush_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic [VLEN-1:0]   boot_addr_i,
  input  logic [VLEN-1:0]   pc_commit_i,
  // Flush events
  input  logic              mispredict_i,
  input  logic              fence_i,
  input  logic              fence_i_i,
  input  logic              sfence_vma_i,
  input  logic              fence_t_i,
  input  logic              flush_csr_i,
  input  logic              flush_commit_i,
  input  logic              ex_valid_i,
  input  logic              eret_i,
  input  logic              halt_csr_i,
  // Cache and timer side
  input  logic              flush_dcache_ack_i,
  input  logic              cache_busy_i,
  input  logic              time_irq_i,
  input  priv_lvl_e         priv_lvl_i,
  // Register port
  input  logic              cfg_we_i,
  input  logic [CFG_AW-1:0] cfg_addr_i,
  input  logic [31:0]       cfg_wdata_i,
  output logic [31:0]       cfg_rdata_o,
  // Flush vector
  output logic              set_pc_commit_o,
  output logic              flush_if_o,
  output logic              flush_unissued_o,
  output logic              flush_id_o,
  output logic              flush_ex_o,
  output logic              flush_bp_o,
  output logic              flush_icache_o,
  output logic              flush_tlb_o,
  output logic              flush_dcache_o,
  output logic              halt_o,
  output logic [VLEN-1:0]   rst_addr_o,
  // fence.t side effects
  output logic              stall_cache_o,
  output logic              rst_uarch_no,
  output logic              cache_init_no
);

  logic [CNT_W-1:0] fence_t_pad;
  logic [CNT_W-1:0] selfinval_period;
  logic             fence_t_src_sel;
  logic             ceil_valid;
  logic [CNT_W-1:0] ceil_value;
  logic             fence_t_busy;

  // ------------------------------------------------------------------------
  // Settings and ceiling
  // ------------------------------------------------------------------------
  fence_cfg_regs u_cfg_regs (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .cfg_we_i          (cfg_we_i),
    .cfg_addr_i        (cfg_addr_i),
    .cfg_wdata_i       (cfg_wdata_i),
    .cfg_rdata_o       (cfg_rdata_o),
    .fence_t_pad_o     (fence_t_pad),
    .selfinval_period_o(selfinval_period),
    .fence_t_src_sel_o (fence_t_src_sel),
    .ceil_valid_i      (ceil_valid),
    .ceil_value_i      (ceil_value)
  );

  // Flush decode and dcache handshake
  flush_ctrl u_flush_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .boot_addr_i       (boot_addr_i),
    .pc_commit_i       (pc_commit_i),
    .mispredict_i      (mispredict_i),
    .fence_i           (fence_i),
    .fence_i_i         (fence_i_i),
    .sfence_vma_i      (sfence_vma_i),
    .fence_t_i         (fence_t_i),
    .flush_csr_i       (flush_csr_i),
    .flush_commit_i    (flush_commit_i),
    .ex_valid_i        (ex_valid_i),
    .eret_i            (eret_i),
    .flush_dcache_ack_i(flush_dcache_ack_i),
    .halt_csr_i        (halt_csr_i),
    .fence_t_busy_i    (fence_t_busy),
    .selfinval_period_i(selfinval_period),
    .set_pc_commit_o   (set_pc_commit_o),
    .flush_if_o        (flush_if_o),
    .flush_unissued_o  (flush_unissued_o),
    .flush_id_o        (flush_id_o),
    .flush_ex_o        (flush_ex_o),
    .flush_bp_o        (flush_bp_o),
    .flush_icache_o    (flush_icache_o),
    .flush_tlb_o       (flush_tlb_o),
    .flush_dcache_o    (flush_dcache_o),
    .halt_o            (halt_o),
    .rst_addr_o        (rst_addr_o)
  );

  // Microreset sequence
  fence_t_fsm u_fence_t_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .fence_t_i         (fence_t_i),
    .flush_dcache_ack_i(flush_dcache_ack_i),
    .cache_busy_i      (cache_busy_i),
    .time_irq_i        (time_irq_i),
    .priv_lvl_i        (priv_lvl_i),
    .fence_t_pad_i     (fence_t_pad),
    .fence_t_src_sel_i (fence_t_src_sel),
    .fence_t_busy_o    (fence_t_busy),
    .stall_cache_o     (stall_cache_o),
    .rst_uarch_no      (rst_uarch_no),
    .cache_init_no     (cache_init_no),
    .ceil_valid_o      (ceil_valid),
    .ceil_value_o      (ceil_value)
  );

endmodule

// File: flush_unit_checker.sv
`timescale 1ns/10ps

module flush_unit_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic flush_dcache_o,
  input logic flush_dcache_ack_i,
  input logic halt_o,
  input logic rst_uarch_no,
  input logic stall_cache_o
);

  // ------------------------------------------------------------------------
  // Dcache flush handshake
  // ------------------------------------------------------------------------

  // Request may only drop once the cache has acknowledged it
  dcache_flush_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    flush_dcache_o && !flush_dcache_ack_i |=> flush_dcache_o
  ) else $error("flush_dcache_o dropped before the acknowledge");

  // ------------------------------------------------------------------------
  // Reset and microreset
  // ------------------------------------------------------------------------
  reset_idle: assert property (
    @(posedge clk_i) $rose(rst_ni) |-> rst_uarch_no && !halt_o
  ) else $error("rst_uarch_no low or halt_o high coming out of reset");

  // Cache stays stalled for the whole microreset pulse
  stall_in_uarch_rst: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !rst_uarch_no |-> stall_cache_o
  ) else $error("stall_cache_o low while rst_uarch_no is asserted");

endmodule

bind flush_unit_top flush_unit_checker u_checker (.*);

// File: tb_flush_unit.sv
`timescale 1ns/10ps

module tb_flush_unit
  import flush_pkg::*;
();

  // ------------------------------------------------------------------------
  // Run constants
  // ------------------------------------------------------------------------
  localparam int CLK_PERIOD_NS = 100;
  localparam int unsigned SEED = 32'hd8ad;
  localparam int N_EV = 9;
  localparam int ENTRY_CYCLES = 24;
  localparam int ACK_MAX_DELAY = 6;
  localparam int PAD_VAL = 200;
  // Ack, busy bursts, drain, pad, microreset and hold-off with margin
  localparam int FENCE_T_CYCLES = PAD_VAL + 120;
  localparam int SELFINV_PERIOD = 12;
  localparam int SETUP_CYCLES = 200;
  localparam int WATCHDOG_CYCLES = N_EV * ENTRY_CYCLES + 2 * FENCE_T_CYCLES + SETUP_CYCLES;
  localparam logic [31:0] BOOT_ADDR = 32'h0001_0000;

  logic              clk_i;
  logic              rst_ni;
  logic [VLEN-1:0]   boot_addr_i;
  logic [VLEN-1:0]   pc_commit_i;
  logic              mispredict_i;
  logic              fence_i;
  logic              fence_i_i;
  logic              sfence_vma_i;
  logic              fence_t_i;
  logic              flush_csr_i;
  logic              flush_commit_i;
  logic              ex_valid_i;
  logic              eret_i;
  logic              halt_csr_i;
  logic              flush_dcache_ack_i;
  logic              cache_busy_i;
  logic              time_irq_i;
  priv_lvl_e         priv_lvl_i;
  logic              cfg_we_i;
  logic [CFG_AW-1:0] cfg_addr_i;
  logic [31:0]       cfg_wdata_i;
  logic [31:0]       cfg_rdata_o;
  logic              set_pc_commit_o;
  logic              flush_if_o;
  logic              flush_unissued_o;
  logic              flush_id_o;
  logic              flush_ex_o;
  logic              flush_bp_o;
  logic              flush_icache_o;
  logic              flush_tlb_o;
  logic              flush_dcache_o;
  logic              halt_o;
  logic [VLEN-1:0]   rst_addr_o;
  logic              stall_cache_o;
  logic              rst_uarch_no;
  logic              cache_init_no;

  int errors = 0;
  int ack_delays [64];
  int ack_idx = 0;

  // ------------------------------------------------------------------------
  // Event table
  // ------------------------------------------------------------------------
  // Stimulus bits {mispredict, fence, fence.i, sfence.vma, fence.t, csr, commit, ex, eret}
  // Expected bits {set_pc, if, unissued, id, ex, bp, icache, tlb}
  // Last entry overlaps a commit flush with an exception
  string      ev_name   [N_EV] = '{"mispredict", "fence", "fence_i", "sfence_vma",
                                    "csr_flush", "commit_flush", "exception", "eret",
                                    "commit_exception"};
  logic [8:0] ev_stim   [N_EV] = '{9'h100, 9'h080, 9'h040, 9'h020,
                                    9'h008, 9'h004, 9'h002, 9'h001, 9'h006};
  logic [7:0] ev_flush  [N_EV] = '{8'h60, 8'hF8, 8'hFA, 8'hF9,
                                    8'hF8, 8'hF8, 8'h7C, 8'h7C, 8'h7C};
  // Only fence and fence.i write back the dcache
  logic       ev_dcache [N_EV] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};

  flush_unit_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("Watchdog expired after %0d cycles, the DUT stopped making progress",
             WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "watchdog timeout");
  end

  // Dcache model that acknowledges each flush after a random delay
  initial begin : cache_model
    int   ack_wait;
    bit   armed;
    logic ack_next;
    flush_dcache_ack_i = 1'b0;
    armed = 1'b0;
    ack_wait = 0;
    forever begin
      @(negedge clk_i);
      ack_next = 1'b0;
      if (rst_ni && flush_dcache_o && !flush_dcache_ack_i) begin
        if (!armed) begin
          armed = 1'b1;
          ack_wait = ack_delays[ack_idx % 64];
          ack_idx++;
        end
        if (ack_wait == 0) begin
          ack_next = 1'b1;
          armed = 1'b0;
        end else begin
          ack_wait--;
        end
      end
      @(posedge clk_i);
      flush_dcache_ack_i <= ack_next;
    end
  end

  // ------------------------------------------------------------------------
  // Checks and reporting
  // ------------------------------------------------------------------------
  task automatic report_mismatch(input string test, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    errors++;
    $display("Error: %s expected 0x%0h actual 0x%0h", test, exp_v, act_v);
    $display("TEST FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string test, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    assert (act_v === exp_v) else report_mismatch(test, exp_v, act_v);
  endtask

  task automatic check_bit(input string test, input logic exp_v, input logic act_v);
    assert (act_v === exp_v) else report_mismatch(test, 32'(exp_v), 32'(act_v));
  endtask

  function automatic logic [7:0] flush_vector();
    return {set_pc_commit_o, flush_if_o, flush_unissued_o, flush_id_o,
            flush_ex_o, flush_bp_o, flush_icache_o, flush_tlb_o};
  endfunction

  task automatic drive_event(input logic [8:0] stim);
    {mispredict_i, fence_i, fence_i_i, sfence_vma_i, fence_t_i,
     flush_csr_i, flush_commit_i, ex_valid_i, eret_i} <= stim;
  endtask

  // Called at the negedge after the event when the request is already up
  task automatic wait_dcache_release(input string test);
    int n;
    n = 0;
    while (!flush_dcache_ack_i) begin
      check_bit({test, " flush_dcache_o held"}, 1'b1, flush_dcache_o);
      check_bit({test, " halt_o held"}, 1'b1, halt_o);
      if (n > ACK_MAX_DELAY + 4) report_failure({test, ": no dcache acknowledge arrived"});
      n++;
      @(negedge clk_i);
    end
    // Request drops the cycle after the ack
    @(negedge clk_i);
    check_bit({test, " flush_dcache_o released"}, 1'b0, flush_dcache_o);
    check_bit({test, " halt_o released"}, 1'b0, halt_o);
  endtask

  task automatic apply_entry(input int i);
    @(posedge clk_i);
    drive_event(ev_stim[i]);
    @(negedge clk_i);
    check_value({ev_name[i], " flush vector"}, 32'(ev_flush[i]), 32'(flush_vector()));
    @(posedge clk_i);
    drive_event('0);
    @(negedge clk_i);
    if (ev_dcache[i]) begin
      wait_dcache_release(ev_name[i]);
    end else begin
      check_bit({ev_name[i], " flush_dcache_o"}, 1'b0, flush_dcache_o);
      check_bit({ev_name[i], " halt_o"}, 1'b0, halt_o);
    end
  endtask

  task automatic cfg_write(input logic [CFG_AW-1:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    cfg_we_i    <= 1'b1;
    cfg_addr_i  <= addr;
    cfg_wdata_i <= data;
    @(posedge clk_i);
    cfg_we_i <= 1'b0;
  endtask

  task automatic cfg_read_check(input string test, input logic [CFG_AW-1:0] addr,
                                input logic [31:0] exp_v);
    @(posedge clk_i);
    cfg_addr_i <= addr;
    @(negedge clk_i);
    check_value(test, exp_v, cfg_rdata_o);
  endtask

  // ------------------------------------------------------------------------
  // fence.t sequence with busy bursts and a timer edge on the event cycle
  // ------------------------------------------------------------------------
  task automatic run_fence_t(input logic [31:0] pc, output logic [31:0] ceil_exp);
    int   cyc;
    int   phase;
    int   idle_run;
    int   drain_exit;
    int   rst_fall;
    int   bursts;
    int   burst_len;
    int   gap;
    int   low_cycles;
    int   hold_cycles;
    logic busy_next;
    @(posedge clk_i);
    pc_commit_i <= pc;
    fence_t_i   <= 1'b1;
    time_irq_i  <= 1'b1;
    @(negedge clk_i);
    check_value("fence_t flush vector", 32'h02, 32'(flush_vector()));
    cyc = 0;
    phase = 1;
    idle_run = 0;
    drain_exit = -1;
    rst_fall = -1;
    bursts = 3;
    burst_len = 0;
    gap = $urandom_range(8, 2);
    while (rst_fall < 0) begin
      @(posedge clk_i);
      fence_t_i  <= 1'b0;
      time_irq_i <= 1'b0;
      // Gaps stay below 16 so drain waits for the last burst
      if (burst_len > 0) begin
        busy_next = 1'b1;
        burst_len--;
      end else if (bursts > 0 && gap == 0) begin
        busy_next = 1'b1;
        burst_len = $urandom_range(4, 1) - 1;
        bursts--;
        gap = $urandom_range(10, 2);
      end else begin
        busy_next = 1'b0;
        if (gap > 0) gap--;
      end
      cache_busy_i <= busy_next;
      cyc++;
      @(negedge clk_i);
      check_bit("fence_t halt_o", 1'b1, halt_o);
      check_bit("fence_t stall_cache_o", 1'b1, stall_cache_o);
      // Reference drain count of 16 idle cycles after the ack cycle
      if (phase == 2) begin
        idle_run = cache_busy_i ? 0 : idle_run + 1;
        if (idle_run == 16) begin
          drain_exit = cyc;
          phase = 3;
        end
      end
      if (phase == 1 && flush_dcache_ack_i) phase = 2;
      if (!rst_uarch_no) rst_fall = cyc;
      if (cyc > FENCE_T_CYCLES) report_failure("fence.t: the microreset never started");
    end
    if (drain_exit < 0) report_failure("fence.t: microreset started before the drain ended");
    // Pad loads one cycle after the timer edge and takes one more cycle to switch state
    check_value("fence_t pad window end", PAD_VAL + 2, rst_fall);
    low_cycles = 0;
    while (!rst_uarch_no) begin
      check_bit("fence_t stall during microreset", 1'b1, stall_cache_o);
      check_bit("fence_t cache_init_no during microreset", 1'b1, cache_init_no);
      low_cycles++;
      if (low_cycles > 2 * RST_UARCH_CYCLES) report_failure("fence.t: microreset stuck low");
      @(negedge clk_i);
    end
    check_value("fence_t microreset length", RST_UARCH_CYCLES, low_cycles);
    hold_cycles = 0;
    while (cache_init_no) begin
      hold_cycles++;
      if (hold_cycles > 4 * CACHE_INIT_HOLD) report_failure("fence.t: cache init held forever");
      @(negedge clk_i);
    end
    check_value("fence_t cache init hold-off", CACHE_INIT_HOLD, hold_cycles);
    check_bit("fence_t stall released", 1'b0, stall_cache_o);
    check_bit("fence_t halt released", 1'b0, halt_o);
    check_value("fence_t resume address", pc + 32'd4, rst_addr_o);
    // Elapsed pad cycles at drain exit
    ceil_exp = drain_exit - 1;
  endtask

  task automatic run_selfinval();
    int n;
    cfg_write(CFG_ADDR_SELFINVAL, SELFINV_PERIOD);
    cfg_read_check("selfinval readback", CFG_ADDR_SELFINVAL, SELFINV_PERIOD);
    n = 0;
    @(negedge clk_i);
    // First request fires at once from an empty counter
    while (!(flush_dcache_o && flush_dcache_ack_i)) begin
      n++;
      if (n > ENTRY_CYCLES) report_failure("selfinval: first flush never acknowledged");
      @(negedge clk_i);
    end
    @(negedge clk_i);
    n = 1;
    while (!flush_dcache_o) begin
      check_bit("selfinval halt between flushes", 1'b0, halt_o);
      n++;
      if (n > 2 * SELFINV_PERIOD) report_failure("selfinval: no periodic flush was raised");
      @(negedge clk_i);
    end
    check_value("selfinval restart delay", SELFINV_PERIOD + 1, n);
    cfg_write(CFG_ADDR_SELFINVAL, 32'h0);
    @(negedge clk_i);
    n = 0;
    while (flush_dcache_o || halt_o) begin
      n++;
      if (n > ENTRY_CYCLES) report_failure("selfinval: flush did not stop after period 0");
      @(negedge clk_i);
    end
  endtask

  // ------------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------------
  initial begin : main
    logic [31:0] ceil_a;
    logic [31:0] ceil_b;
    logic [31:0] ceil_max;
    void'($urandom(SEED));
    for (int i = 0; i < 64; i++) ack_delays[i] = $urandom_range(ACK_MAX_DELAY, 0);
    rst_ni = 1'b0;
    boot_addr_i = BOOT_ADDR;
    pc_commit_i = '0;
    {mispredict_i, fence_i, fence_i_i, sfence_vma_i, fence_t_i} = '0;
    {flush_csr_i, flush_commit_i, ex_valid_i, eret_i} = '0;
    halt_csr_i = 1'b0;
    cache_busy_i = 1'b0;
    time_irq_i = 1'b0;
    priv_lvl_i = PRIV_M;
    cfg_we_i = 1'b0;
    cfg_addr_i = '0;
    cfg_wdata_i = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("reset flush vector", 32'h0, 32'(flush_vector()));
    check_bit("reset flush_dcache_o", 1'b0, flush_dcache_o);
    check_bit("reset halt_o", 1'b0, halt_o);
    check_bit("reset stall_cache_o", 1'b0, stall_cache_o);
    check_bit("reset rst_uarch_no", 1'b1, rst_uarch_no);
    check_bit("reset cache_init_no", 1'b0, cache_init_no);
    check_value("reset rst_addr_o", BOOT_ADDR, rst_addr_o);
    for (int i = 0; i < N_EV; i++) apply_entry(i);
    // Register port
    cfg_read_check("ceiling after reset", CFG_ADDR_CEIL, 32'h0);
    cfg_write(CFG_ADDR_PAD, PAD_VAL);
    cfg_read_check("pad readback", CFG_ADDR_PAD, PAD_VAL);
    cfg_write(CFG_ADDR_SRC_SEL, 32'h3);
    cfg_read_check("source select readback", CFG_ADDR_SRC_SEL, 32'h1);
    cfg_write(CFG_ADDR_SRC_SEL, 32'h0);
    cfg_read_check("source select cleared", CFG_ADDR_SRC_SEL, 32'h0);
    // Two fence.t runs where the ceiling keeps the larger sample
    run_fence_t(32'h8000_1000, ceil_a);
    ceil_max = ceil_a;
    cfg_read_check("ceiling after first fence.t", CFG_ADDR_CEIL, ceil_max);
    run_fence_t(32'h8000_2ffc, ceil_b);
    if (ceil_b > ceil_max) ceil_max = ceil_b;
    cfg_read_check("ceiling after second fence.t", CFG_ADDR_CEIL, ceil_max);
    cfg_write(CFG_ADDR_CEIL, 32'hffff_ffff);
    cfg_read_check("ceiling cleared by write", CFG_ADDR_CEIL, 32'h0);
    run_selfinval();
    if (errors == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "%0d checks failed", errors);
    end
  end

endmodule

// File: files.f
flush_pkg.sv
flush_counter.sv
fence_cfg_regs.sv
flush_ctrl.sv
fence_t_fsm.sv
flush_unit_top.sv
flush_unit_checker.sv
tb_flush_unit.sv

// File: Makefile
# Verilator build and run for the flush unit testbench

VERILATOR ?= verilator
TOP       ?= tb_flush_unit
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) 2>&1 | tee $(LOG)
	@grep -qx "TEST PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
